//--- cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// cache geometry, one 32-bit word per line
`define CACHE_INDEX_W   4       // 16 sets
`define CACHE_OFFSET_W  2       // byte offset inside the word
`define CACHE_TAG_W     26
`define CACHE_WAYS      2

// memory port widths
`define AXI_ADDR_W      32
`define AXI_DATA_W      32

`endif

//--- cache_pkg.sv
`default_nettype none
`include "cache_macros.svh"

package cache_pkg;

    // processor address is tag, index and byte offset back to back
    typedef logic [`CACHE_TAG_W+`CACHE_INDEX_W+`CACHE_OFFSET_W-1:0] addr_t;
    typedef logic [31:0]                   word_t;
    typedef logic [3:0]                    ben_t;     // one bit per byte lane
    typedef logic [`CACHE_TAG_W-1:0]       tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]     index_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

    typedef enum logic [2:0] {
        IDLE,       // hits served here
        WB_ADDR,    // aw and w offered for the dirty victim
        WB_RESP,    // wait for b
        RF_ADDR,    // ar offered
        RF_DATA     // wait for the r beat
    } miss_state_e;

endpackage

`default_nettype wire

//--- axi_pkg.sv
`default_nettype none
`include "cache_macros.svh"

package axi_pkg;

    // single-beat bus, full word per transfer
    typedef logic [`AXI_ADDR_W-1:0] bus_addr_t;
    typedef logic [`AXI_DATA_W-1:0] bus_data_t;

endpackage

`default_nettype wire

//--- cache_lookup.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module cache_lookup (
    input  wire                   clk,
    input  wire                   rst,
    input  wire cache_pkg::addr_t req_addr,
    input  wire                   hit_update,
    input  wire                   store_hit,
    input  wire                   refill_done,
    input  wire cache_pkg::way_t  refill_way,
    output logic                  hit,
    output cache_pkg::way_t       hit_way,
    output cache_pkg::way_t       victim_way,
    output logic                  victim_dirty,
    output cache_pkg::tag_t       victim_tag
);
    localparam int SETS = 1 << `CACHE_INDEX_W;

    cache_pkg::tag_t   tag;
    cache_pkg::index_t index;

    cache_pkg::tag_t                  tags [`CACHE_WAYS][SETS];
    logic [`CACHE_WAYS-1:0][SETS-1:0] valid;
    logic [`CACHE_WAYS-1:0][SETS-1:0] dirty;
    logic [SETS-1:0]                  lru;      // way to replace next
    logic [`CACHE_WAYS-1:0]           match;

    assign tag   = req_addr[`CACHE_OFFSET_W+`CACHE_INDEX_W +: `CACHE_TAG_W];
    assign index = req_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            match[w] = valid[w][index] && (tags[w][index] == tag);
        end
    end

    assign hit     = |match;
    assign hit_way = match[1];  // way 1 only when it matches itself

    // an empty way is filled before anything is evicted
    always_comb begin
        if (!valid[0][index]) begin
            victim_way = 1'b0;
        end else if (!valid[1][index]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru[index];
        end
    end

    assign victim_dirty = dirty[victim_way][index];
    assign victim_tag   = tags[victim_way][index];  // feeds the write-back address

    always_ff @(posedge clk) begin
        if (refill_done) begin
            tags[refill_way][index] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else begin
            if (refill_done) begin
                valid[refill_way][index] <= 1'b1;
                dirty[refill_way][index] <= 1'b0;   // fresh copy of memory
            end
            if (store_hit) begin
                dirty[hit_way][index] <= 1'b1;
            end
            // next victim is the way that was not used
            if (hit_update) begin
                lru[index] <= ~hit_way;
            end
        end
    end

endmodule

`default_nettype wire

//--- cache_miss_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module cache_miss_ctrl (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    req_en,
    input  wire cache_pkg::addr_t  req_addr,
    input  wire                    hit,
    input  wire                    victim_dirty,
    input  wire cache_pkg::tag_t   victim_tag,
    input  wire cache_pkg::way_t   victim_way,
    input  wire cache_pkg::word_t  victim_data,
    input  wire                    arready,
    input  wire                    rvalid,
    input  wire                    rlast,
    input  wire                    awready,
    input  wire                    wready,
    input  wire                    bvalid,
    output logic                   stall,
    output axi_pkg::bus_addr_t     araddr,
    output logic                   arvalid,
    output logic                   rready,
    output axi_pkg::bus_addr_t     awaddr,
    output logic                   awvalid,
    output axi_pkg::bus_data_t     wdata,
    output logic                   wvalid,
    output logic                   bready,
    output logic                   refill_done,
    output cache_pkg::way_t        refill_way
);
    cache_pkg::miss_state_e state;
    cache_pkg::miss_state_e state_next;
    cache_pkg::index_t      index;
    cache_pkg::way_t        way_q;      // victim way held for the whole miss
    logic                   aw_done;
    logic                   w_done;
    logic                   aw_ok;
    logic                   w_ok;
    logic                   miss_start;

    assign index      = req_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign miss_start = (state == cache_pkg::IDLE) && req_en && !hit;

    // aw and w may complete in either order
    assign aw_ok = aw_done || (awvalid && awready);
    assign w_ok  = w_done || (wvalid && wready);

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::IDLE: begin
                if (miss_start) begin
                    state_next = victim_dirty ? cache_pkg::WB_ADDR : cache_pkg::RF_ADDR;
                end
            end
            cache_pkg::WB_ADDR: if (aw_ok && w_ok) state_next = cache_pkg::WB_RESP;
            cache_pkg::WB_RESP: if (bvalid) state_next = cache_pkg::RF_ADDR;
            cache_pkg::RF_ADDR: if (arready) state_next = cache_pkg::RF_DATA;
            cache_pkg::RF_DATA: if (rvalid && rlast) state_next = cache_pkg::IDLE;
            default: state_next = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= cache_pkg::IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state <= state_next;
            if (state_next != cache_pkg::WB_ADDR) begin
                aw_done <= 1'b0;    // cleared for the next write-back
                w_done  <= 1'b0;
            end else begin
                aw_done <= aw_ok;
                w_done  <= w_ok;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss_start) begin
            way_q <= victim_way;
        end
    end

    // stall covers the request cycle of a miss as well
    assign stall = (state != cache_pkg::IDLE) || (req_en && !hit);

    assign araddr  = {req_addr[`AXI_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
    assign arvalid = (state == cache_pkg::RF_ADDR);
    assign rready  = (state == cache_pkg::RF_DATA);

    assign awaddr  = {victim_tag, index, {`CACHE_OFFSET_W{1'b0}}};
    assign awvalid = (state == cache_pkg::WB_ADDR) && !aw_done;
    assign wdata   = victim_data;   // stable, set untouched during the miss
    assign wvalid  = (state == cache_pkg::WB_ADDR) && !w_done;
    assign bready  = (state == cache_pkg::WB_RESP);

    assign refill_done = rready && rvalid && rlast;
    assign refill_way  = way_q;

endmodule

`default_nettype wire

//--- cache_data_bank.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_macros.svh"

module cache_data_bank (
    input  wire                   clk,
    input  wire                   rst,
    input  wire cache_pkg::addr_t req_addr,
    input  wire cache_pkg::way_t  hit_way,
    input  wire                   store_hit,
    input  wire cache_pkg::ben_t  ben,
    input  wire cache_pkg::word_t wdata_in,
    input  wire                   refill_done,
    input  wire cache_pkg::way_t  refill_way,
    input  wire cache_pkg::word_t refill_data,
    input  wire cache_pkg::way_t  victim_way,
    output cache_pkg::word_t      rdata_out,
    output cache_pkg::word_t      victim_data
);
    localparam int SETS = 1 << `CACHE_INDEX_W;

    cache_pkg::index_t index;
    cache_pkg::word_t  mem [`CACHE_WAYS][SETS];

    assign index = req_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

    assign rdata_out   = mem[hit_way][index];       // processor side
    assign victim_data = mem[victim_way][index];    // write-back side

    always_ff @(posedge clk) begin
        if (!rst) begin
            if (refill_done) begin
                mem[refill_way][index] <= refill_data;  // whole line
            end else if (store_hit) begin
                // only the enabled byte lanes change
                for (int b = 0; b < $bits(cache_pkg::ben_t); b++) begin
                    if (ben[b]) begin
                        mem[hit_way][index][8*b +: 8] <= wdata_in[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- d_cache.sv
`timescale 1ns/1ps
`default_nettype none

module d_cache (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    data_en,
    input  wire cache_pkg::addr_t  data_addr,
    input  wire cache_pkg::ben_t   data_wen,
    input  wire cache_pkg::word_t  data_wdata,
    output cache_pkg::word_t       data_rdata,
    output logic                   stall,
    output logic                   hit,
    output axi_pkg::bus_addr_t     araddr,
    output logic                   arvalid,
    input  wire                    arready,
    input  wire axi_pkg::bus_data_t rdata,
    input  wire                    rvalid,
    input  wire                    rlast,
    output logic                   rready,
    output axi_pkg::bus_addr_t     awaddr,
    output logic                   awvalid,
    input  wire                    awready,
    output axi_pkg::bus_data_t     wdata,
    output logic                   wvalid,
    input  wire                    wready,
    input  wire                    bvalid,
    output logic                   bready
);
    logic             way_hit;
    cache_pkg::way_t  hit_way;
    cache_pkg::way_t  victim_way;
    logic             victim_dirty;
    cache_pkg::tag_t  victim_tag;
    cache_pkg::word_t victim_data;
    logic             refill_done;
    cache_pkg::way_t  refill_way;
    logic             hit_update;
    logic             store_hit;

    assign hit_update = data_en && way_hit;             // any access that hits
    assign store_hit  = hit_update && (|data_wen);      // nonzero enables mean a write
    assign hit        = hit_update;

    cache_lookup u_lookup (
        .clk          (clk),
        .rst          (rst),
        .req_addr     (data_addr),
        .hit_update   (hit_update),
        .store_hit    (store_hit),
        .refill_done  (refill_done),
        .refill_way   (refill_way),
        .hit          (way_hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    cache_miss_ctrl u_miss_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req_en       (data_en),
        .req_addr     (data_addr),
        .hit          (way_hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_way   (victim_way),
        .victim_data  (victim_data),
        .arready      (arready),
        .rvalid       (rvalid),
        .rlast        (rlast),
        .awready      (awready),
        .wready       (wready),
        .bvalid       (bvalid),
        .stall        (stall),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .rready       (rready),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .wdata        (wdata),
        .wvalid       (wvalid),
        .bready       (bready),
        .refill_done  (refill_done),
        .refill_way   (refill_way)
    );

    cache_data_bank u_data_bank (
        .clk          (clk),
        .rst          (rst),
        .req_addr     (data_addr),
        .hit_way      (hit_way),
        .store_hit    (store_hit),
        .ben          (data_wen),
        .wdata_in     (data_wdata),
        .refill_done  (refill_done),
        .refill_way   (refill_way),
        .refill_data  (rdata),      // beat goes straight into the line
        .victim_way   (victim_way),
        .rdata_out    (data_rdata),
        .victim_data  (victim_data)
    );

endmodule

`default_nettype wire

//--- tb_axi_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem #(
    parameter int DEPTH = 1024,
    parameter int WAIT  = 2     // wait states before arready, rvalid and awready
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire axi_pkg::bus_addr_t araddr,
    input  wire                     arvalid,
    output logic                    arready,
    output axi_pkg::bus_data_t      rdata,
    output logic                    rvalid,
    output logic                    rlast,
    input  wire                     rready,
    input  wire axi_pkg::bus_addr_t awaddr,
    input  wire                     awvalid,
    output logic                    awready,
    input  wire axi_pkg::bus_data_t wdata,
    input  wire                     wvalid,
    output logic                    wready,
    output logic                    bvalid,
    input  wire                     bready,
    output int                      ar_count,
    output int                      aw_count,
    output axi_pkg::bus_addr_t      last_araddr,
    output axi_pkg::bus_addr_t      last_awaddr,
    output axi_pkg::bus_data_t      last_wdata
);
    localparam int IW = $clog2(DEPTH);

    axi_pkg::bus_data_t words [DEPTH];     // filled by the testbench at time 0
    int                 ar_wait;
    int                 r_wait;
    int                 aw_wait;
    logic               rd_pend;
    logic               aw_got;
    logic               w_got;

    always_ff @(posedge clk) begin
        if (rst) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rlast    <= 1'b0;
            rd_pend  <= 1'b0;
            ar_wait  <= 0;
            r_wait   <= 0;
            ar_count <= 0;
        end else begin
            arready <= 1'b0;
            if (arvalid && arready) begin
                last_araddr <= araddr;
                rd_pend     <= 1'b1;
                ar_count    <= ar_count + 1;
            end else if (arvalid && !rd_pend) begin
                if (ar_wait == WAIT) begin
                    arready <= 1'b1;
                    ar_wait <= 0;
                end else begin
                    ar_wait <= ar_wait + 1;
                end
            end
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rlast   <= 1'b0;
                rd_pend <= 1'b0;
            end else if (rd_pend && !rvalid) begin
                if (r_wait == WAIT) begin
                    rvalid <= 1'b1;
                    rlast  <= 1'b1;     // every beat is the last one
                    rdata  <= words[last_araddr[IW+1:2]];
                    r_wait <= 0;
                end else begin
                    r_wait <= r_wait + 1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            aw_wait  <= 0;
            aw_count <= 0;
        end else begin
            awready <= 1'b0;
            wready  <= 1'b0;
            if (awvalid && awready) begin
                aw_got      <= 1'b1;
                last_awaddr <= awaddr;
                aw_count    <= aw_count + 1;
            end else if (awvalid && !aw_got) begin
                if (aw_wait == WAIT) begin
                    awready <= 1'b1;
                    aw_wait <= 0;
                end else begin
                    aw_wait <= aw_wait + 1;
                end
            end
            // w has no wait states, so it lands before aw
            if (wvalid && wready) begin
                w_got      <= 1'b1;
                last_wdata <= wdata;
            end else if (wvalid && !w_got) begin
                wready <= 1'b1;
            end
            if (aw_got && w_got && !bvalid) begin
                bvalid <= 1'b1;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && aw_got && w_got && !bvalid) begin
            words[last_awaddr[IW+1:2]] <= last_wdata;
        end
    end

endmodule

`default_nettype wire

//--- tb_d_cache_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module tb_d_cache_assertions (
    input wire                     clk,
    input wire                     rst,
    input wire                     stall,
    input wire                     arvalid,
    input wire                     arready,
    input wire axi_pkg::bus_addr_t araddr,
    input wire                     rvalid,
    input wire                     rlast,
    input wire                     awvalid,
    input wire                     awready,
    input wire axi_pkg::bus_addr_t awaddr,
    input wire                     wvalid,
    input wire                     wready,
    input wire axi_pkg::bus_data_t wdata,
    input wire                     bvalid,
    input wire                     bready
);
    logic wb_open;  // aw or w offered, b not yet taken

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_open <= 1'b0;
        end else if (bvalid && bready) begin
            wb_open <= 1'b0;
        end else if (awvalid || wvalid) begin
            wb_open <= 1'b1;
        end
    end

    // valid and payload held until the slave takes them
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr changed before arready");
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid dropped or awaddr changed before awready");
    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("wvalid dropped or wdata changed before wready");

    // refill starts only once the write-back has its response
    ar_after_wb: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> !wb_open && !awvalid && !wvalid)
        else $error("arvalid raised before the write-back finished");
    single_beat: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> rlast)
        else $error("rvalid without rlast");
    idle_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !stall)
        else $error("stall high in the first cycle after reset");

endmodule

`default_nettype wire

//--- tb_d_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_d_cache;
    localparam int DEPTH      = 1024;
    localparam int MISS_MAX   = 16;     // dirty miss with memory wait states rounded up
    localparam int N_DIRECTED = 14;     // accesses in the directed tests
    localparam int N_RANDOM   = 48;
    localparam int LIMIT      = 2 * (N_DIRECTED + N_RANDOM) * MISS_MAX;

    logic               clk;
    logic               rst;
    logic               data_en;
    cache_pkg::addr_t   data_addr;
    cache_pkg::ben_t    data_wen;
    cache_pkg::word_t   data_wdata;
    cache_pkg::word_t   data_rdata;
    logic               stall;
    logic               hit;
    axi_pkg::bus_addr_t araddr;
    logic               arvalid;
    logic               arready;
    axi_pkg::bus_data_t rdata;
    logic               rvalid;
    logic               rlast;
    logic               rready;
    axi_pkg::bus_addr_t awaddr;
    logic               awvalid;
    logic               awready;
    axi_pkg::bus_data_t wdata;
    logic               wvalid;
    logic               wready;
    logic               bvalid;
    logic               bready;
    int                 ar_count;
    int                 aw_count;
    axi_pkg::bus_addr_t last_araddr;
    axi_pkg::bus_addr_t last_awaddr;
    axi_pkg::bus_data_t last_wdata;
    cache_pkg::word_t   ref_mem [DEPTH];
    logic [31:0]        lcg_state;
    int                 cycles;

    d_cache dut0 (.*);
    tb_axi_mem #(.DEPTH(DEPTH)) mem0 (.*);

    bind d_cache tb_d_cache_assertions asrt0 (
        .clk(clk), .rst(rst), .stall(stall),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rlast(rlast),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles <= LIMIT) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout: tests did not finish within %0d cycles", LIMIT);
        $display("Test failed");
        $fatal(1, "simulation timed out");
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic cache_pkg::addr_t make_addr(input logic [5:0] tag, input logic [3:0] set);
        return {20'd0, tag, set, 2'b00};
    endfunction

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "check failed");
    endtask

    task automatic check_word(input string name, input cache_pkg::word_t got,
                              input cache_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_addr(input string name, input axi_pkg::bus_addr_t got,
                              input axi_pkg::bus_addr_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    // one processor request held until stall falls
    task automatic access(input cache_pkg::addr_t addr, input cache_pkg::ben_t ben,
                          input cache_pkg::word_t wd, output cache_pkg::word_t rd,
                          output logic first_hit);
        @(posedge clk);
        data_en    <= 1'b1;
        data_addr  <= addr;
        data_wen   <= ben;
        data_wdata <= wd;
        @(negedge clk);
        first_hit = hit;
        while (stall) begin
            @(negedge clk);
        end
        rd = data_rdata;
        @(posedge clk);     // request completes at this edge
        data_en  <= 1'b0;
        data_wen <= '0;
    endtask

    task automatic do_read(input cache_pkg::addr_t addr, output logic h);
        cache_pkg::word_t rd;
        access(addr, 4'h0, 32'h0, rd, h);
        check_word("data_rdata", rd, ref_mem[addr[11:2]]);
    endtask

    task automatic do_write(input cache_pkg::addr_t addr, input cache_pkg::ben_t ben,
                            input cache_pkg::word_t wd, output logic h);
        cache_pkg::word_t rd;
        access(addr, ben, wd, rd, h);
        for (int b = 0; b < 4; b++) begin
            if (ben[b]) begin
                ref_mem[addr[11:2]][8*b +: 8] = wd[8*b +: 8];
            end
        end
    endtask

    task automatic reset_state_idle();
        @(negedge clk);
        check_bit("stall", stall, 1'b0);
        check_bit("arvalid", arvalid, 1'b0);
        check_bit("awvalid", awvalid, 1'b0);
        check_bit("wvalid", wvalid, 1'b0);
        check_bit("rready", rready, 1'b0);
        check_bit("bready", bready, 1'b0);
    endtask

    task automatic read_miss_then_hit();
        cache_pkg::addr_t a;
        int               ar0;
        logic             h;
        a   = make_addr(6'd1, 4'd3);
        ar0 = ar_count;
        do_read(a, h);
        check_bit("hit", h, 1'b0);
        check_count("ar_count", ar_count, ar0 + 1);
        check_addr("araddr", last_araddr, a);
        do_read(a, h);
        check_bit("hit", h, 1'b1);
        check_count("ar_count", ar_count, ar0 + 1);
    endtask

    task automatic partial_write_hit();
        cache_pkg::addr_t a;
        int               ar0;
        int               aw0;
        logic             h;
        a   = make_addr(6'd1, 4'd3);    // cached by the read test
        ar0 = ar_count;
        aw0 = aw_count;
        do_write(a, 4'b0101, 32'ha5a5_5a5a, h);
        check_bit("hit", h, 1'b1);
        do_read(a, h);
        check_bit("hit", h, 1'b1);
        check_count("ar_count", ar_count, ar0);
        check_count("aw_count", aw_count, aw0);
    endtask

    task automatic dirty_eviction();
        cache_pkg::addr_t a;
        cache_pkg::addr_t c;
        int               ar0;
        int               aw0;
        logic             h;
        a = make_addr(6'd2, 4'd7);
        c = make_addr(6'd4, 4'd7);
        do_write(a, 4'hf, 32'h1234_5678, h);
        do_read(make_addr(6'd3, 4'd7), h);     // a is now the lru way
        ar0 = ar_count;
        aw0 = aw_count;
        do_read(c, h);
        check_count("aw_count", aw_count, aw0 + 1);
        check_addr("awaddr", last_awaddr, a);
        check_word("wdata", last_wdata, ref_mem[a[11:2]]);
        check_count("ar_count", ar_count, ar0 + 1);
        check_addr("araddr", last_araddr, c);
        do_read(a, h);
        check_bit("hit", h, 1'b0);
    endtask

    task automatic lru_replacement();
        cache_pkg::addr_t d;
        cache_pkg::addr_t e;
        int               ar0;
        logic             h;
        d = make_addr(6'd5, 4'd9);
        e = make_addr(6'd6, 4'd9);
        do_read(d, h);
        do_read(e, h);
        do_read(d, h);      // e becomes the lru way
        do_read(make_addr(6'd7, 4'd9), h);
        do_read(d, h);
        check_bit("hit", h, 1'b1);
        ar0 = ar_count;
        do_read(e, h);
        check_bit("hit", h, 1'b0);
        check_count("ar_count", ar_count, ar0 + 1);
    endtask

    task automatic random_mix();
        cache_pkg::addr_t a;
        cache_pkg::ben_t  ben;
        logic             h;
        for (int i = 0; i < N_RANDOM; i++) begin
            lcg_state = lcg_next(lcg_state);
            a   = make_addr(6'(8 + lcg_state[5:4]), 4'(10 + lcg_state[31:16] % 3));
            ben = lcg_state[15:12];
            if (lcg_state[8]) begin
                if (ben == 4'h0) begin
                    ben = 4'hf;
                end
                lcg_state = lcg_next(lcg_state);
                do_write(a, ben, lcg_state, h);
            end else begin
                do_read(a, h);
            end
        end
    endtask

    initial begin
        rst        = 1'b1;
        data_en    = 1'b0;
        data_addr  = '0;
        data_wen   = '0;
        data_wdata = '0;
        lcg_state  = 32'h3901_f343;
        for (int i = 0; i < DEPTH; i++) begin
            lcg_state     = lcg_next(lcg_state);
            mem0.words[i] = lcg_state;
            ref_mem[i]    = lcg_state;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        reset_state_idle();
        read_miss_then_hit();
        partial_write_hit();
        dirty_eviction();
        lru_replacement();
        random_mix();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
cache_pkg.sv
axi_pkg.sv
cache_lookup.sv
cache_miss_ctrl.sv
cache_data_bank.sv
d_cache.sv
tb_axi_mem.sv
tb_d_cache_assertions.sv
tb_d_cache.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator and run; exit status is the simulation result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_d_cache -f sim.f -o tb_d_cache_sim &&
./obj_dir/tb_d_cache_sim ||
{ echo "simulation failed"; exit 1; }
